/* all.f */
verilog/pw_pkg.sv
verilog/pw_capture_packer.sv
verilog/pw_clear_sync.sv
verilog/pw_sniff_fifo.sv
verilog/pw_reg_bank.sv
verilog/pw_sniff_top.sv
testbench/tb_pw_checker.sv
testbench/tb_pw_sniff.sv

/* testbench/tb_pw_sniff.sv */
`default_nettype none
`timescale 1ns/100ps

module tb_pw_sniff;

   localparam int fifo_depth_log2  = 4;
   localparam int short_time_width = 3;
   localparam int fifo_depth       = 2 ** fifo_depth_log2;
   localparam int wait_limit       = 50;

   logic                cwusb_clk;
   logic                fe_clk;
   logic                reset_i;
   pw_pkg::reg_bus_t    bus;
   pw_pkg::reg_byte_t   read_data;
   pw_pkg::fe_capture_t capture;
   pw_pkg::reg_byte_t   sniff_data;
   logic [3:0]          sniff_index;
   logic                sniff_wr;
   logic                capture_enable;
   logic                timestamps_disable;
   logic                trigger_match;
   logic                sample_read;

   // Model of what the DUT should hold
   pw_pkg::fifo_word_t  pending_words[$];
   logic [63:0]         sniff_model;
   pw_pkg::reg_byte_t   fe_last_model;
   int unsigned         fe_count_model;
   int unsigned         reads_since_clear;
   int unsigned         pop_count;
   logic [31:0]         test_value;
   int unsigned         seed_result;

   event                abort_event;
   string               abort_reason;

   pw_sniff_top #(
      .p_fifo_depth_log2  (fifo_depth_log2),
      .p_short_time_width (short_time_width)
   ) uut (
      .cwusb_clk          (cwusb_clk),
      .fe_clk             (fe_clk),
      .reset_i            (reset_i),
      .bus                (bus),
      .read_data          (read_data),
      .capture            (capture),
      .sniff_data         (sniff_data),
      .sniff_index        (sniff_index),
      .sniff_wr           (sniff_wr),
      .capture_enable     (capture_enable),
      .timestamps_disable (timestamps_disable),
      .trigger_match      (trigger_match)
   );

   tb_pw_checker chk (
      .cwusb_clk   (cwusb_clk),
      .read_data   (read_data),
      .sample_read (sample_read)
   );

   always #50 cwusb_clk = ~cwusb_clk;
   always #35 fe_clk = ~fe_clk;

   always @(posedge cwusb_clk) begin
      if (uut.fifo_pop) pop_count <= pop_count + 1;
   end

   ////////////////////////////////////////////////
   // Reference model of the FIFO word layout
   function automatic pw_pkg::fifo_word_t expected_word(input pw_pkg::fe_capture_t cap);
      pw_pkg::fifo_word_t w;
      w.cmd = cap.cmd;
      case (cap.cmd)
         pw_pkg::CMD_DATA: w.payload = {cap.data, cap.stat, cap.timestamp[short_time_width-1:0]};
         pw_pkg::CMD_STAT: w.payload = {8'h00, cap.stat, cap.timestamp[short_time_width-1:0]};
         default:          w.payload = cap.timestamp;
      endcase
      return w;
   endfunction

   function automatic logic control_port(input pw_pkg::reg_addr_t addr);
      logic level;
      case (addr)
         pw_pkg::REG_CAPTURE_ENABLE:     level = capture_enable;
         pw_pkg::REG_TIMESTAMPS_DISABLE: level = timestamps_disable;
         default:                        level = trigger_match;
      endcase
      return level;
   endfunction

   task automatic abort_run(input string reason);
      abort_reason = reason;
      -> abort_event;
   endtask

   // Stops the run after a timeout
   initial begin
      @(abort_event);
      $display("%s", abort_reason);
      $display("FAIL: see errors above");
      $finish;
   end

   task automatic idle_cycles(input int n);
      repeat (n) @(posedge cwusb_clk);
   endtask

   task automatic wait_reset_release;
      int n;
      n = 0;
      while (reset_i && n < wait_limit) begin
         @(posedge cwusb_clk);
         n++;
      end
      if (reset_i) abort_run("timeout: reset_i was never released");
   endtask

   task automatic wait_fifo_data;
      int n;
      n = 0;
      while (uut.fifo_empty && n < wait_limit) begin
         @(posedge cwusb_clk);
         #1;
         n++;
      end
      if (uut.fifo_empty) abort_run("timeout: FIFO stayed empty while a word was due");
   endtask

   ////////////////////////////////////////////////
   // Host bus
   task automatic reg_write_byte(input pw_pkg::reg_addr_t addr, input pw_pkg::byte_cnt_t idx,
                                 input pw_pkg::reg_byte_t data);
      wait_reset_release();
      @(posedge cwusb_clk);
      #5;
      bus.address    = addr;
      bus.bytecnt    = idx;
      bus.write_data = data;
      bus.write      = 1'b1;
      bus.addrvalid  = 1'b1;
      @(posedge cwusb_clk);
      #5;
      bus.write     = 1'b0;
      bus.addrvalid = 1'b0;
   endtask

   task automatic reg_read_byte(input pw_pkg::reg_addr_t addr, input pw_pkg::byte_cnt_t idx,
                                input pw_pkg::reg_byte_t exp_byte, input bit check_it);
      wait_reset_release();
      if (check_it) chk.push_expect(exp_byte);
      @(posedge cwusb_clk);
      #5;
      bus.address   = addr;
      bus.bytecnt   = idx;
      bus.read      = 1'b1;
      bus.addrvalid = 1'b1;
      if (addr == pw_pkg::REG_SNIFF_FIFO_RD) begin
         // FIFO head is combinational and valid before the popping edge
         sample_read = check_it;
         @(posedge cwusb_clk);
         #5;
         bus.read      = 1'b0;
         bus.addrvalid = 1'b0;
         sample_read   = 1'b0;
      end else begin
         @(posedge cwusb_clk);
         #5;
         bus.read      = 1'b0;
         bus.addrvalid = 1'b0;
         sample_read   = check_it;
         @(posedge cwusb_clk);
         #5;
         sample_read = 1'b0;
      end
      reads_since_clear++;
   endtask

   task automatic read_and_check(input pw_pkg::reg_addr_t addr, input logic [63:0] value,
                                 input int nbytes);
      pw_pkg::byte_cnt_t idx;
      for (idx = 0; idx < nbytes; idx++) begin
         reg_read_byte(addr, idx, value[8*idx +: 8], 1'b1);
      end
   endtask

   task automatic drain_word;
      pw_pkg::fifo_word_t w;
      w = pending_words.pop_front();
      wait_fifo_data();
      // Byte 0 last since it pops
      reg_read_byte(pw_pkg::REG_SNIFF_FIFO_RD, 2, {6'b0, w.cmd}, 1'b1);
      reg_read_byte(pw_pkg::REG_SNIFF_FIFO_RD, 1, w.payload[15:8], 1'b1);
      reg_read_byte(pw_pkg::REG_SNIFF_FIFO_RD, 0, w.payload[7:0], 1'b1);
   endtask

   ////////////////////////////////////////////////
   // Front end
   task automatic random_capture(output pw_pkg::fe_capture_t cap);
      logic [31:0] rnd;
      logic [1:0]  cmd_bits;
      rnd           = $urandom;
      cap           = '0;
      cap.timestamp = rnd[15:0];
      cap.data      = rnd[23:16];
      cap.stat      = rnd[28:24];
      rnd           = $urandom_range(2, 0);
      cmd_bits      = rnd[1:0];
      cap.cmd       = pw_pkg::fe_cmd_e'(cmd_bits);
   endtask

   task automatic drive_capture(input pw_pkg::fe_capture_t cap);
      @(posedge fe_clk);
      #5;
      capture    = cap;
      capture.wr = 1'b1;
      @(posedge fe_clk);
      #5;
      capture.wr = 1'b0;
      fe_count_model++;
      if (cap.cmd == pw_pkg::CMD_DATA) fe_last_model = cap.data;
   endtask

   task automatic drive_sniff(input logic [3:0] idx, input pw_pkg::reg_byte_t data);
      @(posedge fe_clk);
      #5;
      sniff_index = idx;
      sniff_data  = data;
      sniff_wr    = 1'b1;
      @(posedge fe_clk);
      #5;
      sniff_wr = 1'b0;
      sniff_model[8*idx +: 8] = data;
   endtask

   ////////////////////////////////////////////////
   // Tests
   task automatic test_reg_test;
      pw_pkg::byte_cnt_t idx;
      chk.start_test("reg_test");
      test_value = $urandom;
      for (idx = 0; idx < 4; idx++) begin
         reg_write_byte(pw_pkg::REG_TEST, idx, test_value[8*idx +: 8]);
      end
      read_and_check(pw_pkg::REG_TEST, test_value, 4);
      chk.end_test();
   endtask

   task automatic toggle_control(input pw_pkg::reg_addr_t addr);
      logic [31:0] rnd;
      rnd = $urandom;
      reg_read_byte(addr, 0, 8'h00, 1'b1);
      // Upper bits are random noise
      reg_write_byte(addr, 0, {rnd[7:1], 1'b1});
      chk.check_value($sformatf("port of register %0h set", addr), 1, control_port(addr));
      reg_read_byte(addr, 0, 8'h01, 1'b1);
      reg_write_byte(addr, 0, {rnd[15:9], 1'b0});
      chk.check_value($sformatf("port of register %0h cleared", addr), 0, control_port(addr));
      reg_read_byte(addr, 0, 8'h00, 1'b1);
   endtask

   task automatic test_control_bits;
      chk.start_test("control_bits");
      chk.check_value("capture_enable after reset", 0, capture_enable);
      chk.check_value("timestamps_disable after reset", 0, timestamps_disable);
      chk.check_value("trigger_match after reset", 0, trigger_match);
      toggle_control(pw_pkg::REG_CAPTURE_ENABLE);
      toggle_control(pw_pkg::REG_TIMESTAMPS_DISABLE);
      toggle_control(pw_pkg::REG_TRIG_MATCH);
      chk.end_test();
   endtask

   task automatic test_fifo_order;
      pw_pkg::fe_capture_t cap;
      int unsigned         pops_before;
      chk.start_test("fifo_order");
      for (int i = 0; i < 10; i++) begin
         random_capture(cap);
         drive_capture(cap);
         pending_words.push_back(expected_word(cap));
      end
      for (int i = 0; i < 10; i++) drain_word();
      idle_cycles(4);
      chk.check_value("fifo empty after drain", 1, uut.fifo_empty);
      // A byte-0 read on an empty FIFO must leave it alone
      pops_before = pop_count;
      reg_read_byte(pw_pkg::REG_SNIFF_FIFO_RD, 0, 8'h00, 1'b0);
      idle_cycles(2);
      chk.check_value("pops on empty FIFO", pops_before, pop_count);
      chk.check_value("fifo empty after empty read", 1, uut.fifo_empty);
      chk.end_test();
   endtask

   task automatic test_fifo_full;
      pw_pkg::fe_capture_t cap;
      chk.start_test("fifo_full");
      for (int i = 0; i < fifo_depth + 4; i++) begin
         random_capture(cap);
         drive_capture(cap);
         if (i < fifo_depth) pending_words.push_back(expected_word(cap));
      end
      idle_cycles(10);
      for (int i = 0; i < fifo_depth; i++) drain_word();
      idle_cycles(4);
      chk.check_value("fifo empty after overfill drain", 1, uut.fifo_empty);
      read_and_check(pw_pkg::REG_FE_WR_CNT, fe_count_model, 4);
      chk.end_test();
   endtask

   task automatic test_fe_registers;
      pw_pkg::fe_capture_t cap;
      logic [31:0]         rnd;
      chk.start_test("fe_registers");
      for (int i = 0; i < 6; i++) begin
         rnd = $urandom;
         drive_sniff({1'b0, rnd[2:0]}, rnd[15:8]);
      end
      random_capture(cap);
      cap.cmd = pw_pkg::CMD_DATA;
      drive_capture(cap);
      idle_cycles(10);
      read_and_check(pw_pkg::REG_FE, fe_last_model, 1);
      read_and_check(pw_pkg::REG_FE_SNIFF, sniff_model, 8);
      read_and_check(pw_pkg::REG_FE_WR_CNT, fe_count_model, 4);
      reg_write_byte(pw_pkg::FE_WR_CNT_CLR, 0, 8'h01);
      fe_count_model = 0;
      idle_cycles(10);
      read_and_check(pw_pkg::REG_FE_WR_CNT, 64'h0, 4);
      chk.end_test();
   endtask

   task automatic test_read_count;
      pw_pkg::byte_cnt_t idx;
      logic [31:0]       count_now;
      chk.start_test("usb_read_count");
      reg_write_byte(pw_pkg::USB_RD_CNT_CLR, 0, 8'h01);
      reads_since_clear = 0;
      read_and_check(pw_pkg::REG_TEST, test_value, 4);
      reg_read_byte(pw_pkg::REG_TEST, 0, test_value[7:0], 1'b1);
      // Each counter byte shows the reads issued before it
      for (idx = 0; idx < 4; idx++) begin
         count_now = reads_since_clear;
         reg_read_byte(pw_pkg::REG_USB_RD_CNT, idx, count_now[8*idx +: 8], 1'b1);
      end
      chk.end_test();
   endtask

   initial begin
      cwusb_clk         = 1'b0;
      fe_clk            = 1'b0;
      reset_i           = 1'b1;
      bus               = '0;
      capture           = '0;
      sniff_data        = '0;
      sniff_index       = '0;
      sniff_wr          = 1'b0;
      sample_read       = 1'b0;
      sniff_model       = '0;
      fe_last_model     = '0;
      fe_count_model    = 0;
      reads_since_clear = 0;
      pop_count         = 0;
      test_value        = '0;
      seed_result       = $urandom(32'h2076);
      repeat (8) @(posedge cwusb_clk);
      #5;
      reset_i = 1'b0;
      test_reg_test();
      test_control_bits();
      test_fifo_order();
      test_fifo_full();
      test_fe_registers();
      test_read_count();
      chk.report();
      if (chk.total_errors == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* testbench/tb_pw_checker.sv */
`default_nettype none
`timescale 1ns/100ps

module tb_pw_checker (
   input wire                    cwusb_clk,
   input wire pw_pkg::reg_byte_t read_data,
   input wire                    sample_read
);

   pw_pkg::reg_byte_t expect_q[$];
   pw_pkg::reg_byte_t expected;
   string             test_name;
   int                test_errors;
   int                test_checks;
   int                read_index;
   int                total_errors;
   int                total_checks;
   int                test_count;

   initial begin
      test_name    = "none";
      test_errors  = 0;
      test_checks  = 0;
      read_index   = 0;
      total_errors = 0;
      total_checks = 0;
      test_count   = 0;
   end

   task automatic start_test(input string name);
      test_name   = name;
      test_errors = 0;
      test_checks = 0;
      read_index  = 0;
      expect_q.delete();
   endtask

   task automatic push_expect(input pw_pkg::reg_byte_t value);
      expect_q.push_back(value);
   endtask

   task automatic check_value(input string label, input logic [31:0] exp_value,
                              input logic [31:0] act_value);
      test_checks++;
      if (act_value !== exp_value) begin
         $display("error %s %s: expected %0h, actual %0h", test_name, label, exp_value,
                  act_value);
         test_errors++;
      end
   endtask

   ////////////////////////////////////////////////
   // Read data is sampled mid-cycle, where it is stable
   always @(negedge cwusb_clk) begin
      if (sample_read) begin
         if (expect_q.size() == 0) begin
            $display("error %s: a read was sampled but no expected value was queued",
                     test_name);
            test_errors++;
         end else begin
            expected = expect_q.pop_front();
            check_value($sformatf("read %0d", read_index), {24'b0, expected},
                        {24'b0, read_data});
            read_index++;
         end
      end
   end

   task automatic end_test;
      if (expect_q.size() != 0) begin
         $display("error %s: %0d expected reads were never sampled", test_name,
                  expect_q.size());
         test_errors++;
         expect_q.delete();
      end
      if (test_errors == 0) begin
         $display("test %s: ok, %0d checks", test_name, test_checks);
      end else begin
         $display("test %s: failed, %0d of %0d checks wrong", test_name, test_errors,
                  test_checks);
      end
      total_errors += test_errors;
      total_checks += test_checks;
      test_count++;
   endtask

   task automatic report;
      $display("%0d tests, %0d checks, %0d errors", test_count, total_checks, total_errors);
   endtask

endmodule

`default_nettype wire

/* verilog/pw_sniff_top.sv */
`default_nettype none
`timescale 1ns/100ps

module pw_sniff_top #(
   parameter int p_fifo_depth_log2  = 4,
   parameter int p_short_time_width = 3
) (
   input  wire                      cwusb_clk,
   input  wire                      fe_clk,
   input  wire                      reset_i,
   input  wire pw_pkg::reg_bus_t    bus,
   output pw_pkg::reg_byte_t        read_data,
   input  wire pw_pkg::fe_capture_t capture,
   input  wire pw_pkg::reg_byte_t   sniff_data,
   input  wire [3:0]                sniff_index,
   input  wire                      sniff_wr,
   output logic                     capture_enable,
   output logic                     timestamps_disable,
   output logic                     trigger_match
);

   pw_pkg::fifo_word_t                    fifo_head;
   pw_pkg::fifo_word_t                    fifo_data;
   logic                                  fifo_empty;
   logic                                  fifo_full;
   logic                                  fifo_pop;
   logic                                  fifo_write;
   pw_pkg::reg_byte_t                     fe_last;
   logic [8*pw_pkg::REG_FE_SNIFF_LEN-1:0] fe_sniff;
   logic [8*pw_pkg::REG_CNT_LEN-1:0]      fe_wr_count;
   logic                                  wr_count_clear;
   logic                                  fe_clear;

   ////////////////////////////////////////////////
   // USB clock domain
   pw_reg_bank u_reg_bank (
      .cwusb_clk          (cwusb_clk),
      .reset_i            (reset_i),
      .bus                (bus),
      .read_data          (read_data),
      .fifo_head          (fifo_head),
      .fifo_empty         (fifo_empty),
      .fifo_pop           (fifo_pop),
      .fe_last            (fe_last),
      .fe_sniff           (fe_sniff),
      .fe_wr_count        (fe_wr_count),
      .wr_count_clear     (wr_count_clear),
      .capture_enable     (capture_enable),
      .timestamps_disable (timestamps_disable),
      .trigger_match      (trigger_match)
   );

   pw_clear_sync u_clear_sync (
      .cwusb_clk   (cwusb_clk),
      .fe_clk      (fe_clk),
      .reset_i     (reset_i),
      .clear_pulse (wr_count_clear),
      .fe_clear    (fe_clear)
   );

   ////////////////////////////////////////////////
   // Front-end clock domain
   pw_capture_packer #(
      .p_short_time_width (p_short_time_width)
   ) u_packer (
      .fe_clk      (fe_clk),
      .reset_i     (reset_i),
      .capture     (capture),
      .sniff_data  (sniff_data),
      .sniff_index (sniff_index),
      .sniff_wr    (sniff_wr),
      .fifo_full   (fifo_full),
      .count_clear (fe_clear),
      .fifo_write  (fifo_write),
      .fifo_data   (fifo_data),
      .fe_last     (fe_last),
      .fe_sniff    (fe_sniff),
      .fe_wr_count (fe_wr_count)
   );

   // Capture words cross from fe_clk to cwusb_clk
   pw_sniff_fifo #(
      .p_fifo_depth_log2 (p_fifo_depth_log2)
   ) u_sniff_fifo (
      .reset_i (reset_i),
      .wr_clk  (fe_clk),
      .write   (fifo_write),
      .wr_data (fifo_data),
      .full    (fifo_full),
      .rd_clk  (cwusb_clk),
      .pop     (fifo_pop),
      .rd_data (fifo_head),
      .empty   (fifo_empty)
   );

endmodule

`default_nettype wire

/* verilog/pw_reg_bank.sv */
`default_nettype none
`timescale 1ns/100ps

module pw_reg_bank (
   input  wire                                    cwusb_clk,
   input  wire                                    reset_i,
   input  wire pw_pkg::reg_bus_t                  bus,
   output pw_pkg::reg_byte_t                      read_data,
   input  wire pw_pkg::fifo_word_t                fifo_head,
   input  wire                                    fifo_empty,
   output logic                                   fifo_pop,
   input  wire pw_pkg::reg_byte_t                 fe_last,
   input  wire [8*pw_pkg::REG_FE_SNIFF_LEN-1:0]   fe_sniff,
   input  wire [8*pw_pkg::REG_CNT_LEN-1:0]        fe_wr_count,
   output logic                                   wr_count_clear,
   output logic                                   capture_enable,
   output logic                                   timestamps_disable,
   output logic                                   trigger_match
);

   logic [8*pw_pkg::REG_TEST_LEN-1:0]     reg_test;
   logic [8*pw_pkg::REG_CNT_LEN-1:0]      usb_rd_count;
   logic                                  usb_rd_count_clear;

   pw_pkg::reg_byte_t                     fe_last_r1;
   pw_pkg::reg_byte_t                     fe_last_r2;
   logic [8*pw_pkg::REG_FE_SNIFF_LEN-1:0] fe_sniff_r1;
   logic [8*pw_pkg::REG_FE_SNIFF_LEN-1:0] fe_sniff_r2;
   logic [8*pw_pkg::REG_CNT_LEN-1:0]      fe_wr_count_r1;
   logic [8*pw_pkg::REG_CNT_LEN-1:0]      fe_wr_count_r2;

   pw_pkg::reg_byte_t                     read_sel;
   pw_pkg::reg_byte_t                     read_reg;
   logic                                  rd_strobe;
   logic                                  wr_strobe;

   assign rd_strobe = bus.addrvalid && bus.read;
   assign wr_strobe = bus.addrvalid && bus.write;

   ////////////////////////////////////////////////
   // Write decode
   always_ff @(posedge cwusb_clk) begin
      if (reset_i) begin
         reg_test           <= '0;
         capture_enable     <= 1'b0;
         timestamps_disable <= 1'b0;
         trigger_match      <= 1'b0;
         usb_rd_count_clear <= 1'b0;
         wr_count_clear     <= 1'b0;
      end else begin
         usb_rd_count_clear <= wr_strobe && bus.address == pw_pkg::USB_RD_CNT_CLR;
         wr_count_clear     <= wr_strobe && bus.address == pw_pkg::FE_WR_CNT_CLR;
         if (wr_strobe) begin
            case (bus.address)
               pw_pkg::REG_TEST: begin
                  if (bus.bytecnt < pw_pkg::REG_TEST_LEN) begin
                     reg_test[bus.bytecnt*8 +: 8] <= bus.write_data;
                  end
               end
               pw_pkg::REG_CAPTURE_ENABLE:     capture_enable     <= bus.write_data[0];
               pw_pkg::REG_TIMESTAMPS_DISABLE: timestamps_disable <= bus.write_data[0];
               pw_pkg::REG_TRIG_MATCH:         trigger_match      <= bus.write_data[0];
               default: ;
            endcase
         end
      end
   end

   // Front-end values cross over through two flops
   always_ff @(posedge cwusb_clk) begin
      fe_last_r1     <= fe_last;
      fe_last_r2     <= fe_last_r1;
      fe_sniff_r1    <= fe_sniff;
      fe_sniff_r2    <= fe_sniff_r1;
      fe_wr_count_r1 <= fe_wr_count;
      fe_wr_count_r2 <= fe_wr_count_r1;
   end

   ////////////////////////////////////////////////
   // Read path
   always_comb begin
      read_sel = '0;
      case (bus.address)
         pw_pkg::REG_TEST: begin
            if (bus.bytecnt < pw_pkg::REG_TEST_LEN) read_sel = reg_test[bus.bytecnt*8 +: 8];
         end
         pw_pkg::REG_FE: begin
            if (bus.bytecnt == '0) read_sel = fe_last_r2;
         end
         pw_pkg::REG_FE_SNIFF: begin
            if (bus.bytecnt < pw_pkg::REG_FE_SNIFF_LEN) begin
               read_sel = fe_sniff_r2[bus.bytecnt*8 +: 8];
            end
         end
         pw_pkg::REG_FE_WR_CNT: begin
            if (bus.bytecnt < pw_pkg::REG_CNT_LEN) read_sel = fe_wr_count_r2[bus.bytecnt*8 +: 8];
         end
         pw_pkg::REG_USB_RD_CNT: begin
            if (bus.bytecnt < pw_pkg::REG_CNT_LEN) read_sel = usb_rd_count[bus.bytecnt*8 +: 8];
         end
         // Control bits read back in bit 0
         pw_pkg::REG_CAPTURE_ENABLE:     read_sel = {7'b0, capture_enable};
         pw_pkg::REG_TIMESTAMPS_DISABLE: read_sel = {7'b0, timestamps_disable};
         pw_pkg::REG_TRIG_MATCH:         read_sel = {7'b0, trigger_match};
         default: read_sel = '0;
      endcase
   end

   always_ff @(posedge cwusb_clk) begin
      if (reset_i) begin
         read_reg     <= '0;
         usb_rd_count <= '0;
      end else begin
         read_reg <= rd_strobe ? read_sel : '0;
         // A read in the clearing cycle still counts
         if (usb_rd_count_clear) begin
            usb_rd_count <= {{(8*pw_pkg::REG_CNT_LEN-1){1'b0}}, rd_strobe};
         end else if (rd_strobe && usb_rd_count != '1) begin
            usb_rd_count <= usb_rd_count + 1'b1;
         end
      end
   end

   // FIFO head bypasses the read register
   always_comb begin
      if (bus.address == pw_pkg::REG_SNIFF_FIFO_RD) begin
         case (bus.bytecnt)
            16'd0:   read_data = fifo_head.payload[7:0];
            16'd1:   read_data = fifo_head.payload[15:8];
            16'd2:   read_data = {6'b0, fifo_head.cmd};
            default: read_data = '0;
         endcase
      end else begin
         read_data = read_reg;
      end
   end

   // Byte 0 is read last, so it advances the queue
   assign fifo_pop = rd_strobe && bus.address == pw_pkg::REG_SNIFF_FIFO_RD &&
                     bus.bytecnt == '0 && !fifo_empty;

endmodule

`default_nettype wire

/* verilog/pw_sniff_fifo.sv */
`default_nettype none
`timescale 1ns/100ps

module pw_sniff_fifo #(
   parameter int p_fifo_depth_log2 = 4
) (
   input  wire                       reset_i,
   input  wire                       wr_clk,
   input  wire                       write,
   input  wire pw_pkg::fifo_word_t   wr_data,
   output logic                      full,
   input  wire                       rd_clk,
   input  wire                       pop,
   output pw_pkg::fifo_word_t        rd_data,
   output logic                      empty
);

   localparam int c_depth = 2 ** p_fifo_depth_log2;

   // Top two Gray bits differ when the writer is one lap ahead
   localparam logic [p_fifo_depth_log2:0] c_full_mask = 3 << (p_fifo_depth_log2 - 1);

   pw_pkg::fifo_word_t mem [c_depth];

   logic [p_fifo_depth_log2:0] wr_bin;
   logic [p_fifo_depth_log2:0] wr_bin_next;
   logic [p_fifo_depth_log2:0] wr_gray;
   logic [p_fifo_depth_log2:0] rd_gray_w1;
   logic [p_fifo_depth_log2:0] rd_gray_w2;

   logic [p_fifo_depth_log2:0] rd_bin;
   logic [p_fifo_depth_log2:0] rd_bin_next;
   logic [p_fifo_depth_log2:0] rd_gray;
   logic [p_fifo_depth_log2:0] wr_gray_r1;
   logic [p_fifo_depth_log2:0] wr_gray_r2;

   logic do_write;
   logic do_read;

   ////////////////////////////////////////////////
   // Write side, fe_clk domain
   assign full        = (wr_gray == (rd_gray_w2 ^ c_full_mask));
   assign do_write    = write && !full;
   assign wr_bin_next = wr_bin + 1'b1;

   always_ff @(posedge wr_clk) begin
      if (do_write) begin
         mem[wr_bin[p_fifo_depth_log2-1:0]] <= wr_data;
      end
   end

   always_ff @(posedge wr_clk) begin
      if (reset_i) begin
         wr_bin     <= '0;
         wr_gray    <= '0;
         rd_gray_w1 <= '0;
         rd_gray_w2 <= '0;
      end else begin
         rd_gray_w1 <= rd_gray;
         rd_gray_w2 <= rd_gray_w1;
         if (do_write) begin
            wr_bin  <= wr_bin_next;
            wr_gray <= wr_bin_next ^ (wr_bin_next >> 1);
         end
      end
   end

   ////////////////////////////////////////////////
   // Read side, cwusb_clk domain
   assign empty       = (rd_gray == wr_gray_r2);
   assign do_read     = pop && !empty;
   assign rd_bin_next = rd_bin + 1'b1;

   // Head of the queue shown without a read latency
   assign rd_data = mem[rd_bin[p_fifo_depth_log2-1:0]];

   always_ff @(posedge rd_clk) begin
      if (reset_i) begin
         rd_bin     <= '0;
         rd_gray    <= '0;
         wr_gray_r1 <= '0;
         wr_gray_r2 <= '0;
      end else begin
         wr_gray_r1 <= wr_gray;
         wr_gray_r2 <= wr_gray_r1;
         if (do_read) begin
            rd_bin  <= rd_bin_next;
            rd_gray <= rd_bin_next ^ (rd_bin_next >> 1);
         end
      end
   end

endmodule

`default_nettype wire

/* verilog/pw_clear_sync.sv */
`default_nettype none
`timescale 1ns/100ps

module pw_clear_sync (
   input  wire  cwusb_clk,
   input  wire  fe_clk,
   input  wire  reset_i,
   input  wire  clear_pulse,
   output logic fe_clear
);

   logic       usb_toggle;
   logic [2:0] fe_sync;

   // Each pulse flips the level
   always_ff @(posedge cwusb_clk) begin
      if (reset_i) begin
         usb_toggle <= 1'b0;
      end else if (clear_pulse) begin
         usb_toggle <= ~usb_toggle;
      end
   end

   // Two synchronizer stages plus one for the edge detect
   always_ff @(posedge fe_clk) begin
      if (reset_i) begin
         fe_sync <= '0;
      end else begin
         fe_sync <= {fe_sync[1:0], usb_toggle};
      end
   end

   assign fe_clear = fe_sync[2] ^ fe_sync[1];

endmodule

`default_nettype wire

/* verilog/pw_capture_packer.sv */
`default_nettype none
`timescale 1ns/100ps

module pw_capture_packer #(
   parameter int p_short_time_width = 3
) (
   input  wire                                   fe_clk,
   input  wire                                   reset_i,
   input  wire pw_pkg::fe_capture_t              capture,
   input  wire pw_pkg::reg_byte_t                sniff_data,
   input  wire [3:0]                             sniff_index,
   input  wire                                   sniff_wr,
   input  wire                                   fifo_full,
   input  wire                                   count_clear,
   output logic                                  fifo_write,
   output pw_pkg::fifo_word_t                    fifo_data,
   output pw_pkg::reg_byte_t                     fe_last,
   output logic [8*pw_pkg::REG_FE_SNIFF_LEN-1:0] fe_sniff,
   output logic [8*pw_pkg::REG_CNT_LEN-1:0]      fe_wr_count
);

   pw_pkg::fifo_word_t next_word;
   logic               accept;

   assign accept = capture.wr && !fifo_full;

   // Format one capture into a FIFO word
   always_comb begin
      next_word     = '0;
      next_word.cmd = capture.cmd;
      case (capture.cmd)
         pw_pkg::CMD_DATA: begin
            next_word.payload[pw_pkg::DATA_LSB +: 8] = capture.data;
            next_word.payload[pw_pkg::STAT_LSB +: 5] = capture.stat;
            next_word.payload[p_short_time_width-1:0] =
               capture.timestamp[p_short_time_width-1:0];
         end
         pw_pkg::CMD_STAT: begin
            // Data byte stays zero
            next_word.payload[pw_pkg::STAT_LSB +: 5] = capture.stat;
            next_word.payload[p_short_time_width-1:0] =
               capture.timestamp[p_short_time_width-1:0];
         end
         pw_pkg::CMD_TIME: begin
            next_word.payload = capture.timestamp;
         end
         default: begin
            next_word.payload = '0;
         end
      endcase
   end

   always_ff @(posedge fe_clk) begin
      if (reset_i) begin
         fifo_write <= 1'b0;
      end else begin
         fifo_write <= accept;
      end
      if (accept) begin
         fifo_data <= next_word;
      end
   end

   ////////////////////////////////////////////////
   // Front-end status registers
   always_ff @(posedge fe_clk) begin
      if (reset_i) begin
         fe_last     <= '0;
         fe_sniff    <= '0;
         fe_wr_count <= '0;
      end else begin
         if (capture.wr && capture.cmd == pw_pkg::CMD_DATA) begin
            fe_last <= capture.data;
         end
         if (sniff_wr && sniff_index < pw_pkg::REG_FE_SNIFF_LEN) begin
            fe_sniff[sniff_index*8 +: 8] <= sniff_data;
         end
         // Dropped captures count too
         if (count_clear) begin
            fe_wr_count <= '0;
         end else if (capture.wr && fe_wr_count != '1) begin
            fe_wr_count <= fe_wr_count + 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

/* verilog/pw_pkg.sv */
`default_nettype none

package pw_pkg;

   ////////////////////////////////////////////////
   // Scalar types
   typedef logic [5:0]  reg_addr_t;
   typedef logic [7:0]  reg_byte_t;
   typedef logic [15:0] byte_cnt_t;
   typedef logic [15:0] fe_time_t;
   typedef logic [4:0]  fe_stat_t;

   // Capture kinds, as stored in the top bits of a FIFO word
   typedef enum logic [1:0] {
      CMD_DATA = 2'b00,
      CMD_STAT = 2'b01,
      CMD_TIME = 2'b10
   } fe_cmd_e;

   // Payload layout for data and status words
   localparam int DATA_LSB = 8;
   localparam int STAT_LSB = 3;

   typedef struct packed {
      fe_cmd_e     cmd;
      logic [15:0] payload;
   } fifo_word_t;

   typedef struct packed {
      fe_time_t  timestamp;
      reg_byte_t data;
      fe_stat_t  stat;
      fe_cmd_e   cmd;
      logic      wr;
   } fe_capture_t;

   typedef struct packed {
      reg_addr_t address;
      byte_cnt_t bytecnt;
      reg_byte_t write_data;
      logic      read;
      logic      write;
      logic      addrvalid;
   } reg_bus_t;

   ////////////////////////////////////////////////
   // Register map
   localparam reg_addr_t REG_TEST               = 6'h00;
   localparam reg_addr_t REG_SNIFF_FIFO_RD      = 6'h01;
   localparam reg_addr_t REG_TIMESTAMPS_DISABLE = 6'h02;
   localparam reg_addr_t REG_CAPTURE_ENABLE     = 6'h03;
   localparam reg_addr_t REG_FE                 = 6'h04;
   localparam reg_addr_t REG_FE_SNIFF           = 6'h05;
   localparam reg_addr_t REG_FE_WR_CNT          = 6'h06;
   localparam reg_addr_t REG_USB_RD_CNT         = 6'h07;
   localparam reg_addr_t USB_RD_CNT_CLR         = 6'h08;
   localparam reg_addr_t FE_WR_CNT_CLR          = 6'h09;
   localparam reg_addr_t REG_TRIG_MATCH         = 6'h0a;

   // Register lengths in bytes
   localparam int REG_TEST_LEN     = 4;
   localparam int REG_FE_SNIFF_LEN = 8;
   localparam int REG_CNT_LEN      = 4;

endpackage

`default_nettype wire
